/* audio_config.svh */
`ifndef AUDIO_CONFIG_SVH
`define AUDIO_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Sample format
//////////////////////////////////////////////////////////////////////

`define AUDIO_SAMPLE_W   8                              // Bits per sample
`define AUDIO_MIDSCALE   (1 << (`AUDIO_SAMPLE_W - 1))   // Offset binary zero

//////////////////////////////////////////////////////////////////////
// Memory and sample rate
//////////////////////////////////////////////////////////////////////

// Short values keep simulation brief
// Hardware build: 2000 per half, 12 address bits, 3500 clocks per sample
`define AUDIO_HALF_DEPTH 32   // Samples per channel half
`define AUDIO_ADDR_W     6    // Covers left and right halves
`define AUDIO_PRESCALE   24   // Clocks per sample period

`endif

/* audio_pkg.sv */
`include "audio_config.svh"

package audio_pkg;

   // One audio sample, offset binary
   typedef logic [`AUDIO_SAMPLE_W-1:0] sampleT;

   // Sample memory address, upper half is right channel
   typedef logic [`AUDIO_ADDR_W-1:0] memAddrT;

   // Loader to memory write
   typedef struct packed {
      logic    en;     // Write strobe, one cycle
      memAddrT addr;
      sampleT  data;
   } memWriteT;

   // Sequencer to output stage
   typedef struct packed {
      sampleT sample;
      logic   chan;    // 0 left, 1 right
   } playItemT;

   // Four-phase write handshake
   typedef enum logic [1:0] {
      idle, write, ackHigh, waitReqLow
   } loaderStateT;

endpackage

/* sample_loader.sv */
`timescale 1ns/10ps

module sample_loader (
   input  logic                Clk,
   input  logic                arstN,
   input  logic                loadReq,
   input  audio_pkg::memAddrT  loadAddr,
   input  audio_pkg::sampleT   loadData,
   output logic                loadAck,
   output audio_pkg::memWriteT memWr
);
   import audio_pkg::*;

   loaderStateT state;
   logic        wrEn;
   memAddrT     wrAddr;
   sampleT      wrData;

   // Handshake FSM, ack rises two cycles after req
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         state   <= idle;
         wrEn    <= 1'b0;
         loadAck <= 1'b0;
      end else begin
         wrEn <= 1'b0;                // Strobe lasts one cycle
         case (state)
            idle: begin
               if (loadReq) begin
                  state <= write;
                  wrEn  <= 1'b1;
               end
            end
            write: begin                // Memory takes the write here
               state   <= ackHigh;
               loadAck <= 1'b1;
            end
            ackHigh: begin
               if (!loadReq) begin      // Early release
                  state   <= idle;
                  loadAck <= 1'b0;
               end else
                  state <= waitReqLow;
            end
            waitReqLow: begin
               if (!loadReq) begin      // Ack falls one cycle after req
                  state   <= idle;
                  loadAck <= 1'b0;
               end
            end
            default: state <= idle;
         endcase
      end
   end

   // Address and data latched with the request
   always_ff @(posedge Clk) begin
      if (state == idle && loadReq) begin
         wrAddr <= loadAddr;
         wrData <= loadData;
      end
   end

   assign memWr = '{en: wrEn, addr: wrAddr, data: wrData};

   // Host must wait for ack low before a new request
   reqAfterAck : assert property (@(posedge Clk) disable iff (!arstN)
      $rose(loadReq) |-> !loadAck)
      else $error("loadReq raised while loadAck still high");

endmodule

/* sample_mem.sv */
`timescale 1ns/10ps
`include "audio_config.svh"

module sample_mem (
   input  logic                Clk,
   input  audio_pkg::memWriteT memWr,
   input  audio_pkg::memAddrT  rdAddr,
   output audio_pkg::sampleT   rdData
);
   import audio_pkg::*;

   localparam int Depth = 2 * `AUDIO_HALF_DEPTH;  // Left half then right half

   //////////////////////////////////////////////////////////////////////
   // Storage, powers up silent
   //////////////////////////////////////////////////////////////////////

   sampleT mem [0:Depth-1] = '{default: sampleT'(`AUDIO_MIDSCALE)};

   // Write port from loader
   always_ff @(posedge Clk) begin
      if (memWr.en)
         mem[memWr.addr] <= memWr.data;
   end

   // Registered read, one cycle latency
   always_ff @(posedge Clk) begin
      rdData <= mem[rdAddr];
   end

endmodule

/* playback_sequencer.sv */
`timescale 1ns/10ps
`include "audio_config.svh"

module playback_sequencer (
   input  logic                Clk,
   input  logic                arstN,
   input  logic                playEn,
   output audio_pkg::memAddrT  rdAddr,
   input  audio_pkg::sampleT   rdData,
   output audio_pkg::playItemT playItem
);
   import audio_pkg::*;

   localparam int      CntW     = $clog2(`AUDIO_PRESCALE);
   localparam memAddrT HalfAddr = memAddrT'(`AUDIO_HALF_DEPTH);        // First right sample
   localparam memAddrT LastAddr = memAddrT'(2 * `AUDIO_HALF_DEPTH - 1);
   localparam playItemT IdleItem = '{sample: sampleT'(`AUDIO_MIDSCALE), chan: 1'b0};

   logic [CntW-1:0] cnt;       // Prescaler
   logic            tick;      // High for one cycle per sample period
   memAddrT         addr;      // Next address to read
   logic            rdVld;     // Read issued last edge
   logic            rdChan;
   logic            dataVld;   // rdData holds the sample
   logic            dataChan;

   //////////////////////////////////////////////////////////////////////
   // Prescaler, address walk and read pipeline
   //////////////////////////////////////////////////////////////////////

   // Tick edge T: address out, T+1: memory read, T+2: playItem
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         cnt      <= '0;
         tick     <= 1'b0;
         addr     <= '0;
         rdAddr   <= '0;
         rdVld    <= 1'b0;
         rdChan   <= 1'b0;
         dataVld  <= 1'b0;
         dataChan <= 1'b0;
         playItem <= IdleItem;
      end else if (!playEn) begin  // Idle, restart from address 0
         cnt      <= '0;
         tick     <= 1'b0;
         addr     <= '0;
         rdAddr   <= '0;
         rdVld    <= 1'b0;
         rdChan   <= 1'b0;
         dataVld  <= 1'b0;
         dataChan <= 1'b0;
         playItem <= IdleItem;
      end else begin
         // Wrap registers the tick, so first tick lands PRESCALE edges in
         tick <= (cnt == CntW'(`AUDIO_PRESCALE - 1));
         if (cnt == CntW'(`AUDIO_PRESCALE - 1))
            cnt <= '0;
         else
            cnt <= cnt + 1'b1;

         if (tick) begin
            rdAddr <= addr;
            rdChan <= (addr >= HalfAddr);              // Upper half is right
            addr   <= (addr == LastAddr) ? '0 : addr + 1'b1;
         end

         rdVld    <= tick;
         dataVld  <= rdVld;
         dataChan <= rdChan;                           // Channel rides with data

         if (dataVld)
            playItem <= '{sample: rdData, chan: dataChan};
      end
   end

   // Output moves only on the third edge after a tick, or on idle
   itemTiming : assert property (@(posedge Clk) disable iff (!arstN)
      $changed(playItem) |-> $past(tick, 3) || !$past(playEn))
      else $error("playItem changed outside its delivery slot");

endmodule

/* pdm_output.sv */
`timescale 1ns/10ps
`include "audio_config.svh"

module pdm_output (
   input  logic                Clk,
   input  logic                arstN,
   input  audio_pkg::playItemT playItem,
   output logic                left,
   output logic                right,
   output logic                led1,
   output logic                led2
);

   localparam int              AccW    = `AUDIO_SAMPLE_W + 2;
   localparam logic [AccW-1:0] AccInit = AccW'(1) << `AUDIO_SAMPLE_W;  // 0x100

   logic [AccW-1:0] acc;       // Sigma register
   logic [AccW-1:0] delta;     // Sample plus feedback
   logic            accMsb;
   logic            pulse;     // Modulator output one cycle behind acc

   //////////////////////////////////////////////////////////////////////
   // First-order delta-sigma modulator
   //////////////////////////////////////////////////////////////////////

   assign accMsb = acc[AccW-1];

   // Feedback adds 0x300 when the accumulator overflowed
   assign delta = AccW'(playItem.sample)
                + {accMsb, accMsb, {`AUDIO_SAMPLE_W{1'b0}}};

   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         acc   <= AccInit;
         pulse <= 1'b0;
      end else begin
         acc   <= acc + delta;
         pulse <= accMsb;      // Old top bit
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Channel steering
   //////////////////////////////////////////////////////////////////////

   assign left  = pulse & ~playItem.chan;   // Inactive pin held low
   assign right = pulse & playItem.chan;
   assign led1  = ~playItem.chan;           // Left playing
   assign led2  = playItem.chan;

   // Sigma stays between 0x100 and 0x2FF for any sample value
   accBand : assert property (@(posedge Clk) disable iff (!arstN)
      acc[AccW-1] != acc[AccW-2])
      else $error("accumulator left its stable band");

endmodule

/* audio_player_top.sv */
`timescale 1ns/10ps

module audio_player_top (
   input  logic               Clk,
   input  logic               arstN,
   input  logic               loadReq,   // Host write port
   input  audio_pkg::memAddrT loadAddr,
   input  audio_pkg::sampleT  loadData,
   output logic               loadAck,
   input  logic               playEn,
   output logic               left,      // Pulse pins
   output logic               right,
   output logic               led1,      // Channel indicators
   output logic               led2
);
   import audio_pkg::*;

   memWriteT memWr;
   memAddrT  rdAddr;
   sampleT   rdData;
   playItemT playItem;

   sample_loader uLoader (
      .Clk      (Clk),
      .arstN    (arstN),
      .loadReq  (loadReq),
      .loadAddr (loadAddr),
      .loadData (loadData),
      .loadAck  (loadAck),
      .memWr    (memWr)
   );

   sample_mem uMem (
      .Clk    (Clk),
      .memWr  (memWr),
      .rdAddr (rdAddr),
      .rdData (rdData)
   );

   playback_sequencer uSeq (
      .Clk      (Clk),
      .arstN    (arstN),
      .playEn   (playEn),
      .rdAddr   (rdAddr),
      .rdData   (rdData),
      .playItem (playItem)
   );

   pdm_output uOut (
      .Clk      (Clk),
      .arstN    (arstN),
      .playItem (playItem),
      .left     (left),
      .right    (right),
      .led1     (led1),
      .led2     (led2)
   );

endmodule

/* tb_clock.sv */
`timescale 1ns/10ps

module tb_clock #(
   parameter int PeriodNs    = 20,
   parameter int ResetCycles = 3
) (
   output logic Clk,
   output logic arstN
);

   initial begin
      Clk = 1'b0;
      forever #(PeriodNs / 2) Clk = ~Clk;
   end

   // Release lands on a rising edge, like every other input
   initial begin
      arstN = 1'b0;
      repeat (ResetCycles) @(posedge Clk);
      arstN <= 1'b1;
   end

endmodule

/* tb_audio.sv */
`timescale 1ns/10ps
`include "audio_config.svh"

module tb_audio;
   import audio_pkg::*;

   localparam int H        = `AUDIO_HALF_DEPTH;
   localparam int P        = `AUDIO_PRESCALE;
   localparam int Depth    = 2 * H;
   localparam int ItemLag  = 3;                      // Edges from tick register to playItem
   localparam int RightAt  = (H + 1) * P + ItemLag;  // playEn edge to first right sample
   localparam int PeriodNs = 20;
   localparam int WatchNs  = (Depth * 16 + 3 * Depth * P) * PeriodNs;  // Loads, passes, margin
   localparam int SelAck   = 0;
   localparam int SelRight = 1;
   localparam int SelLeft  = 2;

   logic        Clk, arstN, loadReq, loadAck, playEn, left, right, led1, led2;
   memAddrT     loadAddr;
   sampleT      loadData;
   int          errors = 0;
   logic [31:0] lfsr = 32'h5bcc;

   // Reference model state
   sampleT      memModel [0:Depth-1];
   int          playCount, pendAt;     // Edges since playEn rose, delivery edge
   memAddrT     nextAddr, pendAddr;
   logic        pendValid, itemChan, pulseModel;
   sampleT      itemSample;
   logic [9:0]  accModel, feedback;
   logic        expLeft, expRight;

   memAddrT     order [0:Depth-1];     // Load order
   memAddrT     swapTmp;
   int          idx, pick;

   tb_clock #(.PeriodNs(PeriodNs), .ResetCycles(3)) uClock (.Clk(Clk), .arstN(arstN));

   audio_player_top uut (.*);

   //////////////////////////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////////////////////////

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] randBits(input int n);
      logic [31:0] r;
      int          i;
      r = '0;
      for (i = 0; i < n; i++) begin
         r    = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return r;
   endfunction

   task automatic reportMismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
      errors++;
      $display("[FAIL] %s expected 0x%0h got 0x%0h at %0t", name, exp, got, $time);
   endtask

   task automatic reportProblem(input string what);
      errors++;
      $display("Problem at %0t: %s", $time, what);
   endtask

   // Counts rising edges until the chosen output reaches level
   // Sampled mid-cycle
   task automatic expectEdges(input int sel, input logic level, input int want,
                              input string name);
      int n;
      bit hit;
      n   = 0;
      hit = 1'b0;
      while (!hit && n < want + 8) begin
         @(posedge Clk);
         n++;
         @(negedge Clk);
         hit = (((sel == SelAck) ? loadAck : (sel == SelRight) ? led2 : led1) === level);
      end
      if (!hit)
         reportProblem({name, " never reached its level"});
      else if (n != want)
         reportMismatch({name, " edges"}, want, n);
   endtask

   // One four-phase write with random hold and gap
   task automatic loadSample(input memAddrT addr, input sampleT data);
      @(posedge Clk);
      loadAddr <= addr;
      loadData <= data;
      loadReq  <= 1'b1;
      memModel[addr] = data;
      expectEdges(SelAck, 1'b1, 2, "loadAck rise");
      repeat (randBits(2)) @(posedge Clk);   // Host holds req a while
      @(posedge Clk);
      loadReq <= 1'b0;
      expectEdges(SelAck, 1'b0, 1, "loadAck fall");
      repeat (randBits(2)) @(posedge Clk);   // Gap before the next request
   endtask

   //////////////////////////////////////////////////////////////////////
   // Reference model stepped on each edge with pre-edge inputs
   //////////////////////////////////////////////////////////////////////

   always @(posedge Clk) begin
      if (!arstN) begin
         playCount  = 0;
         nextAddr   = '0;
         pendValid  = 1'b0;
         itemSample = sampleT'(`AUDIO_MIDSCALE);
         itemChan   = 1'b0;
         accModel   = 10'h100;
         pulseModel = 1'b0;
      end else begin
         // Delta-sigma step on the item held before this edge
         feedback   = accModel[9] ? 10'h300 : 10'h000;
         pulseModel = accModel[9];           // Pin lags acc by one cycle
         accModel   = accModel + {2'b00, itemSample} + feedback;
         if (!playEn) begin                  // Idle plays midscale on left
            playCount  = 0;
            nextAddr   = '0;
            pendValid  = 1'b0;
            itemSample = sampleT'(`AUDIO_MIDSCALE);
            itemChan   = 1'b0;
         end else begin
            playCount++;
            if (pendValid && playCount == pendAt) begin
               itemSample = memModel[pendAddr];
               itemChan   = pendAddr[`AUDIO_ADDR_W-1];   // Upper half is right
               pendValid  = 1'b0;
            end
            if (playCount % P == 0) begin    // Sample tick
               pendValid = 1'b1;
               pendAt    = playCount + ItemLag;
               pendAddr  = nextAddr;
               nextAddr  = (nextAddr == memAddrT'(Depth - 1)) ? '0 : nextAddr + 1'b1;
            end
         end
      end
   end

   // Pins and LEDs compared mid-cycle
   always @(negedge Clk) begin
      if (arstN) begin
         expLeft  = pulseModel & ~itemChan;
         expRight = pulseModel & itemChan;
         if (left !== expLeft)
            reportMismatch("left", 32'(expLeft), 32'(left));
         if (right !== expRight)
            reportMismatch("right", 32'(expRight), 32'(right));
         if (led2 !== itemChan)
            reportMismatch("led2", 32'(itemChan), 32'(led2));
         if (led1 === led2)
            reportProblem("led1 and led2 show the same level");
         if (left && right)
            reportProblem("left and right pins high together");
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      loadReq  = 1'b0;
      loadAddr = '0;
      loadData = '0;
      playEn   = 1'b0;
      for (idx = 0; idx < Depth; idx++) begin
         memModel[idx] = sampleT'(`AUDIO_MIDSCALE);   // Memory powers up silent
         order[idx]    = memAddrT'(idx);
      end
      wait (arstN === 1'b1);
      @(negedge Clk);
      if (loadAck !== 1'b0)
         reportMismatch("loadAck", 32'h0, 32'(loadAck));
      if (led1 !== 1'b1 || led2 !== 1'b0)
         reportProblem("LEDs do not show left after reset");
      if (left !== 1'b0 || right !== 1'b0)
         reportProblem("pulse pins not low after reset");

      // Shuffled load order
      for (idx = Depth - 1; idx > 0; idx--) begin
         pick        = int'(randBits(6) % (idx + 1));
         swapTmp     = order[idx];
         order[idx]  = order[pick];
         order[pick] = swapTmp;
      end
      for (idx = 0; idx < Depth; idx++)
         loadSample(order[idx], sampleT'(randBits(`AUDIO_SAMPLE_W)));

      // Right half, back to left after a pass, right again
      @(posedge Clk);
      playEn <= 1'b1;
      expectEdges(SelRight, 1'b1, RightAt, "led2 rise");
      expectEdges(SelLeft, 1'b1, H * P, "led1 return");
      expectEdges(SelRight, 1'b1, H * P, "led2 second rise");

      repeat (randBits(6)) @(posedge Clk);   // Stop somewhere in the right half
      @(posedge Clk);
      playEn <= 1'b0;
      expectEdges(SelLeft, 1'b1, 1, "led1 on idle");
      repeat (P + randBits(5)) @(posedge Clk);

      // Restart from address 0 with a full first prescale period
      @(posedge Clk);
      playEn <= 1'b1;
      expectEdges(SelRight, 1'b1, RightAt, "led2 after restart");
      repeat (P) @(posedge Clk);
      @(negedge Clk);

      $display("Run complete, %0d errors", errors);
      if (errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

   initial begin
      #(WatchNs);
      $display("Watchdog expired before the test sequence finished");
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

/* verilog.f */
+incdir+.
audio_pkg.sv
sample_loader.sv
sample_mem.sv
playback_sequencer.sv
pdm_output.sv
audio_player_top.sv
tb_clock.sv
tb_audio.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_audio -f verilog.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vtb_audio > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
   echo "Simulation failed"
   exit 1
fi

echo "Simulation passed"
exit 0
